// ==== design/dma_settings.svh ====
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// number of request/acknowledge channel pairs
`define DMA_CHANNELS 4

// cpu data bus, one byte per register access
`define DMA_DATA_WIDTH 8

// address and word count registers are two bytes wide
`define DMA_ADDR_WIDTH 16

// register select from the cpu side
`define DMA_REG_ADDR_WIDTH 4

// write loads the command register, read returns status
`define DMA_REG_COMMAND 8
// write loads one channel's mode, channel in bits 1:0
`define DMA_REG_MODE 11
// write clears the byte pointer flip-flop
`define DMA_REG_CLEAR_FF 12

// command byte bit that picks rotating priority when set
`define DMA_CMD_PRIORITY_BIT 4

`endif

// ==== design/dmaPkg.sv ====
`include "dma_settings.svh"

package dmaPkg;

	// one byte on the cpu data bus
	typedef logic [`DMA_DATA_WIDTH-1:0] dataByte;

	// memory address presented during a transfer
	typedef logic [`DMA_ADDR_WIDTH-1:0] addressWord;

	// remaining transfers minus one
	typedef logic [`DMA_ADDR_WIDTH-1:0] countWord;

	// channel number, 0 to 3
	typedef logic [$clog2(`DMA_CHANNELS)-1:0] channelIndex;

	// one bit per channel, used for dreq, dack and tc
	typedef logic [`DMA_CHANNELS-1:0] channelVec;

	// cpu register select
	typedef logic [`DMA_REG_ADDR_WIDTH-1:0] regAddr;

	// 8237 style timing states, S3 is not needed without slow memory
	typedef enum logic [2:0] {
		stateSI,
		stateSO,
		stateS1,
		stateS2,
		stateS4
	} timingState;

	// mode register transfer type, code 3 acts like verify
	typedef enum logic [1:0] {
		xferVerify = 2'd0,
		xferWrite  = 2'd1,
		xferRead   = 2'd2
	} transferType;

endpackage

// ==== design/dmaRegisterFile.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module dmaRegisterFile (
	input  logic                busIf,
	input  logic                rst,
	input  logic                csN,
	input  logic                iorN,
	input  logic                iowN,
	input  dmaPkg::regAddr      regAddr,
	input  dmaPkg::dataByte     dataIn,
	input  dmaPkg::channelVec   dreq,
	input  dmaPkg::channelIndex grantChannel,
	input  logic                transferDone,
	output dmaPkg::dataByte     dataOut,
	output dmaPkg::channelVec   tcFlags,
	output logic                rotatingPriority,
	output dmaPkg::transferType grantType,
	output dmaPkg::addressWord  grantAddress
);

	// per channel word registers
	dmaPkg::addressWord  baseAddress    [`DMA_CHANNELS];
	dmaPkg::addressWord  currentAddress [`DMA_CHANNELS];
	dmaPkg::countWord    baseCount      [`DMA_CHANNELS];
	dmaPkg::countWord    currentCount   [`DMA_CHANNELS];
	dmaPkg::transferType modeReg        [`DMA_CHANNELS];

	// byte pointer, 0 = low byte, 1 = high byte
	logic bytePointer;

	logic                cpuRead;
	logic                cpuWrite;
	logic                channelAccess;
	logic                channelWrite;
	dmaPkg::channelIndex chSel;
	logic                isCount;
	dmaPkg::addressWord  readWord;
	dmaPkg::dataByte     readByte;

	// one cycle with the strobe low is one access
	assign cpuRead  = !csN && !iorN;
	assign cpuWrite = !csN && !iowN;

	// codes 0 to 7 hit the channel registers
	assign channelAccess = (cpuRead || cpuWrite) && !regAddr[`DMA_REG_ADDR_WIDTH-1];
	assign channelWrite  = cpuWrite && !regAddr[`DMA_REG_ADDR_WIDTH-1];
	assign chSel         = regAddr[2:1];
	assign isCount       = regAddr[0];

	// granted channel as seen by the address bus and the strobe decode
	assign grantAddress = currentAddress[grantChannel];
	assign grantType    = modeReg[grantChannel];

	// read mux, only the current copies are visible
	always_comb
	begin
		readWord = isCount ? currentCount[chSel] : currentAddress[chSel];
		readByte = '0;
		if (!regAddr[`DMA_REG_ADDR_WIDTH-1])
		begin
			readByte = bytePointer ? readWord[`DMA_ADDR_WIDTH-1:`DMA_DATA_WIDTH]
				: readWord[`DMA_DATA_WIDTH-1:0];
		end
		else if (regAddr == dmaPkg::regAddr'(`DMA_REG_COMMAND))
		begin
			// status: raw requests on top, tc flags below
			readByte = {dreq, tcFlags};
		end
	end

	// control state: pointer, tc flags, command and mode
	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			bytePointer      <= 1'b0;
			tcFlags          <= '1;
			rotatingPriority <= 1'b0;
			modeReg          <= '{default: dmaPkg::xferVerify};
		end
		else
		begin
			// count was already zero, this transfer was the last one
			if (transferDone && (currentCount[grantChannel] == '0))
				tcFlags[grantChannel] <= 1'b1;
			if (channelAccess)
				bytePointer <= ~bytePointer;
			if (cpuWrite && (regAddr == dmaPkg::regAddr'(`DMA_REG_CLEAR_FF)))
				bytePointer <= 1'b0;
			if (cpuWrite && (regAddr == dmaPkg::regAddr'(`DMA_REG_COMMAND)))
				rotatingPriority <= dataIn[`DMA_CMD_PRIORITY_BIT];
			if (cpuWrite && (regAddr == dmaPkg::regAddr'(`DMA_REG_MODE)))
				modeReg[dataIn[1:0]] <= dmaPkg::transferType'(dataIn[3:2]);
			// reprogramming the count re-arms the channel
			if (channelWrite && isCount && bytePointer)
				tcFlags[chSel] <= 1'b0;
		end
	end

	// address and count words plus the read buffer
	always_ff @(posedge busIf)
	begin
		if (transferDone)
		begin
			currentAddress[grantChannel] <= currentAddress[grantChannel] + 1'b1;
			currentCount[grantChannel]   <= currentCount[grantChannel] - 1'b1;
		end
		// cpu writes come last so they win over a finishing transfer
		if (channelWrite && !isCount)
		begin
			if (!bytePointer)
			begin
				baseAddress[chSel][`DMA_DATA_WIDTH-1:0]    <= dataIn;
				currentAddress[chSel][`DMA_DATA_WIDTH-1:0] <= dataIn;
			end
			else
			begin
				baseAddress[chSel][`DMA_ADDR_WIDTH-1:`DMA_DATA_WIDTH] <= dataIn;
				// high byte commits the whole base word into current
				currentAddress[chSel] <= {dataIn, baseAddress[chSel][`DMA_DATA_WIDTH-1:0]};
			end
		end
		if (channelWrite && isCount)
		begin
			if (!bytePointer)
			begin
				baseCount[chSel][`DMA_DATA_WIDTH-1:0]    <= dataIn;
				currentCount[chSel][`DMA_DATA_WIDTH-1:0] <= dataIn;
			end
			else
			begin
				baseCount[chSel][`DMA_ADDR_WIDTH-1:`DMA_DATA_WIDTH] <= dataIn;
				currentCount[chSel] <= {dataIn, baseCount[chSel][`DMA_DATA_WIDTH-1:0]};
			end
		end
		// read data appears one cycle later and holds
		if (cpuRead)
			dataOut <= readByte;
	end

endmodule

// ==== design/dmaPriorityArbiter.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module dmaPriorityArbiter (
	input  logic                busIf,
	input  logic                rst,
	input  dmaPkg::channelVec   dreq,
	input  dmaPkg::channelVec   tcFlags,
	input  logic                rotatingPriority,
	input  logic                grantLatch,
	input  logic                transferDone,
	output logic                anyEligible,
	output dmaPkg::channelIndex grantChannel
);

	dmaPkg::channelVec   eligible;
	// channel that currently ranks highest in rotating mode
	dmaPkg::channelIndex topChannel;
	dmaPkg::channelIndex startChannel;
	dmaPkg::channelIndex candidate;
	dmaPkg::channelIndex winner;
	logic                found;

	// a channel past terminal count is ignored
	assign eligible    = dreq & ~tcFlags;
	assign anyEligible = |eligible;

	// fixed priority always starts the search at channel 0
	assign startChannel = rotatingPriority ? topChannel : '0;

	// walk the channels from the top ranked one, first hit wins
	always_comb
	begin
		winner    = startChannel;
		found     = 1'b0;
		candidate = startChannel;
		for (int i = 0; i < `DMA_CHANNELS; i++)
		begin
			candidate = dmaPkg::channelIndex'(startChannel + i);
			if (!found && eligible[candidate])
			begin
				winner = candidate;
				found  = 1'b1;
			end
		end
	end

	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			grantChannel <= '0;
			topChannel   <= '0;
		end
		else
		begin
			// grant is frozen for the whole service cycle
			if (grantLatch)
				grantChannel <= winner;
			// served channel drops to lowest, its neighbour goes first
			if (transferDone)
				topChannel <= grantChannel + 1'b1;
		end
	end

endmodule

// ==== design/dmaTimingControl.sv ====
`timescale 1ns/1ps

module dmaTimingControl (
	input  logic                busIf,
	input  logic                rst,
	input  logic                csN,
	input  logic                hlda,
	input  logic                anyEligible,
	input  dmaPkg::channelIndex grantChannel,
	input  dmaPkg::transferType grantType,
	output logic                hrq,
	output logic                aen,
	output logic                adstb,
	output logic                ioReadN,
	output logic                ioWriteN,
	output logic                memReadN,
	output logic                memWriteN,
	output logic                grantLatch,
	output logic                transferDone,
	output dmaPkg::channelVec   dack
);

	dmaPkg::timingState state;
	dmaPkg::timingState nextState;

	always_ff @(posedge busIf)
	begin
		if (rst)
			state <= dmaPkg::stateSI;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			dmaPkg::stateSI:
			begin
				// the cpu owns the chip while csN is low
				if (csN && anyEligible)
					nextState = dmaPkg::stateSO;
			end
			dmaPkg::stateSO:
			begin
				// hold request is out so wait for the bus
				if (hlda)
				begin
					// request may have gone away while waiting
					if (anyEligible)
						nextState = dmaPkg::stateS1;
					else
						nextState = dmaPkg::stateSI;
				end
			end
			dmaPkg::stateS1:
				nextState = dmaPkg::stateS2;
			dmaPkg::stateS2:
				nextState = dmaPkg::stateS4;
			dmaPkg::stateS4:
				// single transfer mode gives the bus back every time
				nextState = dmaPkg::stateSI;
			default:
				nextState = dmaPkg::stateSI;
		endcase
	end

	// winner is sampled on the edge that leaves SO for S1
	assign grantLatch = (state == dmaPkg::stateSO) && hlda && anyEligible;

	// counters update on the edge that leaves S4
	assign transferDone = (state == dmaPkg::stateS4);

	// hold request from SO through S2 and dropped in S4
	assign hrq = (state == dmaPkg::stateSO) || (state == dmaPkg::stateS1)
		|| (state == dmaPkg::stateS2);

	// address enable spans S1 and S2
	assign aen = (state == dmaPkg::stateS1) || (state == dmaPkg::stateS2);

	// strobe marks the first cycle with a valid address
	assign adstb = (state == dmaPkg::stateS1);

	// one-hot acknowledge for the granted channel in S2 only
	assign dack = (state == dmaPkg::stateS2) ? (dmaPkg::channelVec'(1) << grantChannel) : '0;

	// active low bus strobes only during S2
	always_comb
	begin
		ioReadN   = 1'b1;
		ioWriteN  = 1'b1;
		memReadN  = 1'b1;
		memWriteN = 1'b1;
		if (state == dmaPkg::stateS2)
		begin
			case (grantType)
				dmaPkg::xferWrite:
				begin
					// device to memory
					ioReadN   = 1'b0;
					memWriteN = 1'b0;
				end
				dmaPkg::xferRead:
				begin
					// memory to device
					memReadN = 1'b0;
					ioWriteN = 1'b0;
				end
				default:
				begin
					// verify and code 3 run the cycle with no strobe
				end
			endcase
		end
	end

endmodule

// ==== design/dmaController.sv ====
`timescale 1ns/1ps

module dmaController (
	input  logic               busIf,
	input  logic               rst,
	input  logic               csN,
	input  logic               iorN,
	input  logic               iowN,
	input  logic               hlda,
	input  dmaPkg::regAddr     regAddr,
	input  dmaPkg::dataByte    dataIn,
	input  dmaPkg::channelVec  dreq,
	output dmaPkg::dataByte    dataOut,
	output logic               hrq,
	output logic               aen,
	output logic               adstb,
	output logic               ioReadN,
	output logic               ioWriteN,
	output logic               memReadN,
	output logic               memWriteN,
	output dmaPkg::channelVec  dack,
	output dmaPkg::addressWord address
);

	dmaPkg::channelVec   tcFlags;
	logic                rotatingPriority;
	dmaPkg::transferType grantType;
	dmaPkg::channelIndex grantChannel;
	logic                anyEligible;
	logic                grantLatch;
	logic                transferDone;

	// cpu registers, counters and read-back
	dmaRegisterFile i_registerFile (
		.busIf(busIf), .rst(rst), .csN(csN), .iorN(iorN), .iowN(iowN),
		.regAddr(regAddr), .dataIn(dataIn), .dreq(dreq),
		.grantChannel(grantChannel), .transferDone(transferDone),
		.dataOut(dataOut), .tcFlags(tcFlags), .rotatingPriority(rotatingPriority),
		.grantType(grantType), .grantAddress(address)
	);

	// picks and holds the channel to serve
	dmaPriorityArbiter i_priorityArbiter (
		.busIf(busIf), .rst(rst), .dreq(dreq), .tcFlags(tcFlags),
		.rotatingPriority(rotatingPriority), .grantLatch(grantLatch),
		.transferDone(transferDone), .anyEligible(anyEligible),
		.grantChannel(grantChannel)
	);

	// hold handshake and bus cycle sequencing
	dmaTimingControl i_timingControl (
		.busIf(busIf), .rst(rst), .csN(csN), .hlda(hlda), .anyEligible(anyEligible),
		.grantChannel(grantChannel), .grantType(grantType),
		.hrq(hrq), .aen(aen), .adstb(adstb), .ioReadN(ioReadN), .ioWriteN(ioWriteN),
		.memReadN(memReadN), .memWriteN(memWriteN), .grantLatch(grantLatch),
		.transferDone(transferDone), .dack(dack)
	);

endmodule

// ==== testbench/dmaControllerTb.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module dmaControllerTb;

	logic busIf, rst, csN, iorN, iowN, hlda;
	logic hrq, aen, adstb, ioReadN, ioWriteN, memReadN, memWriteN;
	dmaPkg::regAddr     regAddr;
	dmaPkg::dataByte    dataIn;
	dmaPkg::dataByte    dataOut;
	dmaPkg::channelVec  dreq;
	dmaPkg::channelVec  dack;
	dmaPkg::addressWord address;

	// reference copy of every channel kept from the register and service rules
	dmaPkg::addressWord  refAddr  [`DMA_CHANNELS];
	dmaPkg::countWord    refCount [`DMA_CHANNELS];
	logic [1:0]          refType  [`DMA_CHANNELS];
	dmaPkg::channelVec   refTc;
	dmaPkg::channelIndex refTop;
	logic                refRotating;
	logic                refPointer;
	integer              seed;
	dmaPkg::channelVec   seenDack;
	dmaPkg::channelVec   tcBefore;

	dmaController i_dut (.*);

	initial
	begin
		busIf = 1'b0;
		forever #50 busIf = ~busIf;
	end

	task automatic abortRun(input string reason);
		$display("test failed");
		$display("%s", reason);
		$fatal(1);
	endtask

	task automatic expectEqual(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected)
		else
			abortRun($sformatf("Mismatch at %0t: %s expected %0h actual %0h", $time, name,
				expected, actual));
	endtask

	// one register access with csN and one strobe low for a single cycle
	task automatic cpuAccess(input logic write, input dmaPkg::regAddr code,
		input dmaPkg::dataByte data);
		@(negedge busIf);
		csN     = 1'b0;
		regAddr = code;
		dataIn  = data;
		iowN    = !write;
		iorN    = write;
		@(negedge busIf);
		csN  = 1'b1;
		iowN = 1'b1;
		iorN = 1'b1;
	endtask

	task automatic writeReg(input dmaPkg::regAddr code, input dmaPkg::dataByte data);
		dmaPkg::channelIndex ch;
		ch = code[2:1];
		cpuAccess(1'b1, code, data);
		if (!code[3])
		begin
			if (!code[0])
				refAddr[ch] = refPointer ? {data, refAddr[ch][7:0]} : {refAddr[ch][15:8], data};
			else if (refPointer)
			begin
				refCount[ch] = {data, refCount[ch][7:0]};
				// high count byte re-arms the channel
				refTc[ch] = 1'b0;
			end
			else
				refCount[ch] = {refCount[ch][15:8], data};
			refPointer = !refPointer;
		end
		else if (code == `DMA_REG_CLEAR_FF)
			refPointer = 1'b0;
		else if (code == `DMA_REG_COMMAND)
			refRotating = data[`DMA_CMD_PRIORITY_BIT];
		else if (code == `DMA_REG_MODE)
			refType[data[1:0]] = data[3:2];
	endtask

	// status for code 8 and otherwise the byte the pointer selects
	task automatic readReg(input dmaPkg::regAddr code);
		dmaPkg::countWord word;
		dmaPkg::dataByte  expected;
		word     = code[0] ? refCount[code[2:1]] : refAddr[code[2:1]];
		expected = refPointer ? word[15:8] : word[7:0];
		if (code[3])
			expected = {dreq, refTc};
		else
			refPointer = !refPointer;
		cpuAccess(1'b0, code, 8'h00);
		expectEqual("dataOut", expected, dataOut);
	endtask

	task automatic programChannel(input dmaPkg::channelIndex ch,
		input dmaPkg::addressWord addr, input dmaPkg::countWord count);
		writeReg({1'b0, ch, 1'b0}, addr[7:0]);
		writeReg({1'b0, ch, 1'b0}, addr[15:8]);
		writeReg({1'b0, ch, 1'b1}, count[7:0]);
		writeReg({1'b0, ch, 1'b1}, count[15:8]);
	endtask

	// new random address and a count of minCount to minCount+3 on all channels
	task automatic rearmChannels(input int minCount);
		writeReg(`DMA_REG_CLEAR_FF, 8'h00);
		for (int ch = 0; ch < `DMA_CHANNELS; ch++)
			programChannel(ch, $random(seed), minCount + {$random(seed)} % 4);
	endtask

	// search starts at channel 0 or at the rotation pointer when rotating
	function automatic dmaPkg::channelIndex expectedWinner(input dmaPkg::channelVec eligible);
		int start;
		start = refRotating ? refTop : 0;
		for (int i = 0; i < `DMA_CHANNELS; i++)
		begin
			if (eligible[(start + i) % `DMA_CHANNELS])
				return dmaPkg::channelIndex'((start + i) % `DMA_CHANNELS);
		end
		return dmaPkg::channelIndex'(start);
	endfunction

	// one full service cycle for the dreq now driven that returns the dack seen in S2
	task automatic serveOne(output dmaPkg::channelVec observed);
		dmaPkg::channelVec   eligible;
		dmaPkg::channelIndex ch;
		int                  delay;
		int                  cycles;
		logic [3:0]          strobes;
		eligible = dreq & ~refTc;
		cycles   = 0;
		while (!hrq)
		begin
			@(negedge busIf);
			cycles++;
			if (cycles > 8)
				abortRun("timeout waiting for hrq to rise");
		end
		expectEqual("aen", 1'b0, aen);
		// bus grant returns after a random latency and hrq must hold meanwhile
		delay = {$random(seed)} % 6;
		repeat (delay)
		begin
			@(negedge busIf);
			expectEqual("hrq", 1'b1, hrq);
			expectEqual("aen", 1'b0, aen);
		end
		hlda   = 1'b1;
		ch     = expectedWinner(eligible);
		cycles = 0;
		while (!adstb)
		begin
			@(negedge busIf);
			cycles++;
			if (cycles > 3)
				abortRun("timeout waiting for adstb after hlda");
		end
		// S1 is the first cycle with the address out
		expectEqual("aen", 1'b1, aen);
		expectEqual("dack", 4'b0000, dack);
		expectEqual("address", refAddr[ch], address);
		@(negedge busIf);
		// S2 carries the acknowledge and the strobes
		expectEqual("adstb", 1'b0, adstb);
		expectEqual("aen", 1'b1, aen);
		expectEqual("hrq", 1'b1, hrq);
		expectEqual("dack", 4'b0001 << ch, dack);
		observed = dack;
		// order is ioReadN, ioWriteN, memReadN, memWriteN
		case (refType[ch])
			2'd1: strobes = 4'b0110;
			2'd2: strobes = 4'b1001;
			default: strobes = 4'b1111;
		endcase
		expectEqual("strobes", strobes, {ioReadN, ioWriteN, memReadN, memWriteN});
		@(negedge busIf);
		// S4 hands the bus back
		expectEqual("hrq", 1'b0, hrq);
		expectEqual("aen", 1'b0, aen);
		expectEqual("dack", 4'b0000, dack);
		if (refCount[ch] == 16'h0000)
			refTc[ch] = 1'b1;
		refAddr[ch]  = refAddr[ch] + 1'b1;
		refCount[ch] = refCount[ch] - 1'b1;
		refTop       = ch + 1;
		hlda         = 1'b0;
		dreq         = '0;
	endtask

	// bus rules that hold in every cycle
	always @(posedge busIf)
	begin
		if (!rst)
		begin
			assert (ioReadN || ioWriteN)
			else
				abortRun("ioReadN and ioWriteN were low together");
			assert ((dack != '0) || ({ioReadN, ioWriteN, memReadN, memWriteN} == 4'hf))
			else
				abortRun("a bus strobe was low while dack was zero");
			assert (!adstb || aen)
			else
				abortRun("adstb was high while aen was low");
			assert ((dack & (dack - 1'b1)) == '0)
			else
				abortRun("dack had more than one bit set");
		end
	end

	initial
	begin
		seed        = 32'h38fe_a5d8;
		rst         = 1'b1;
		csN         = 1'b1;
		iorN        = 1'b1;
		iowN        = 1'b1;
		hlda        = 1'b0;
		regAddr     = '0;
		dataIn      = '0;
		dreq        = '0;
		refTc       = '1;
		refTop      = '0;
		refRotating = 1'b0;
		refPointer  = 1'b0;
		for (int ch = 0; ch < `DMA_CHANNELS; ch++)
		begin
			refAddr[ch]  = '0;
			refCount[ch] = '0;
			refType[ch]  = 2'd0;
		end
		repeat (3) @(posedge busIf);
		@(negedge busIf);
		rst = 1'b0;
		expectEqual("hrq", 1'b0, hrq);
		expectEqual("aen", 1'b0, aen);
		expectEqual("adstb", 1'b0, adstb);
		expectEqual("dack", 4'b0000, dack);
		expectEqual("strobes", 4'hf, {ioReadN, ioWriteN, memReadN, memWriteN});
		readReg(`DMA_REG_COMMAND);
		// full random words first and then read back low and high byte of each
		rearmChannels({$random(seed)});
		writeReg(`DMA_REG_CLEAR_FF, 8'h00);
		for (int code = 0; code < 8; code++)
		begin
			readReg(code);
			readReg(code);
		end
		readReg(`DMA_REG_COMMAND);
		// channel n gets mode code n so code 3 is covered too
		for (int ch = 0; ch < `DMA_CHANNELS; ch++)
			writeReg(`DMA_REG_MODE, dmaPkg::dataByte'((ch << 2) | ch));
		rearmChannels(0);
		for (int n = 0; n < 60; n++)
		begin
			if (refTc == 4'b1111)
				rearmChannels(0);
			dreq     = $random(seed);
			tcBefore = refTc;
			if ((dreq & ~refTc) != '0)
				serveOne(seenDack);
			else
			begin
				// only finished channels request so the controller stays idle
				readReg(`DMA_REG_COMMAND);
				expectEqual("hrq", 1'b0, hrq);
				dreq = '0;
			end
			if (refTc != tcBefore)
				readReg(`DMA_REG_COMMAND);
		end
		// serving channel 3 leaves channel 0 on top
		rearmChannels(8);
		dreq = 4'b1000;
		serveOne(seenDack);
		writeReg(`DMA_REG_COMMAND, dmaPkg::dataByte'(1 << `DMA_CMD_PRIORITY_BIT));
		for (int n = 0; n < 5; n++)
		begin
			dreq = 4'b1111;
			serveOne(seenDack);
			expectEqual("dack in rotation", 4'b0001 << (n % 4), seenDack);
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+design
design/dmaPkg.sv
design/dmaRegisterFile.sv
design/dmaPriorityArbiter.sv
design/dmaTimingControl.sv
design/dmaController.sv
testbench/dmaControllerTb.sv

// ==== Bender.yml ====
package:
  name: dma_controller

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/dmaPkg.sv
      - design/dmaRegisterFile.sv
      - design/dmaPriorityArbiter.sv
      - design/dmaTimingControl.sv
      - design/dmaController.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/dmaControllerTb.sv
